/* dv/ppu_asserts.sv */
// bound to ppu_top; output gating by mode, one-cycle interrupts and OAM scan length
`timescale 1ns/1ps

module ppu_asserts import ppu_pkg::*; #(
    parameter int scan_dots = 80
) (
    input logic      clk,
    input logic      rst,
    input lcdc_u     lcdc,
    input ppu_mode_e ppu_mode,
    input vram_req_t vram,
    input logic      px_valid,
    input logic      irq_lcdc,
    input logic      irq_vblank
);

    logic failed = 1'b0; // sticky, watched by the testbench

    a_px_in_draw: assert property (@(posedge clk) disable iff (rst)
        px_valid |-> ppu_mode == mode_draw)
        else begin failed = 1'b1; $error("px_valid high outside draw"); end

    // every tile fetch finishes its reads before draw ends
    a_vram_in_draw: assert property (@(posedge clk) disable iff (rst)
        vram.rd |=> ppu_mode == mode_draw)
        else begin failed = 1'b1; $error("vram read in the last draw cycle"); end

    a_irq_lcdc_pulse: assert property (@(posedge clk) disable iff (rst)
        irq_lcdc |=> !irq_lcdc)
        else begin failed = 1'b1; $error("irq_lcdc longer than one cycle"); end

    a_irq_vblank_pulse: assert property (@(posedge clk) disable iff (rst)
        irq_vblank |=> !irq_vblank)
        else begin failed = 1'b1; $error("irq_vblank longer than one cycle"); end

    // line start into OAM scan, draw follows after scan_dots cycles
    a_scan_length: assert property (@(posedge clk) disable iff (rst || !lcdc.flags.lcd_en)
        $rose(ppu_mode == mode_oam_scan) |-> ##scan_dots ppu_mode == mode_draw)
        else begin failed = 1'b1; $error("OAM scan did not last scan_dots cycles"); end

endmodule

/* dv/ppu_tb.sv */
// testbench for the background-only PPU; default timing, VRAM answers addr[7:0] ^ addr[15:8]
`timescale 1ns/1ps

module ppu_tb import ppu_pkg::*; ();

    localparam int line_cycles    = 456;
    localparam int timeout_cycles = (154 + 16 + 8 + 10) * line_cycles; // one frame, two short runs

    logic       clk = 1'b0;
    logic       rst;
    mmio_bus_t  mmio;
    logic [7:0] rdata;
    logic       irq_vblank;
    logic       irq_lcdc;
    ppu_mode_e  ppu_mode;
    vram_req_t  vram;
    vram_req_t  vram_req_q;
    logic [7:0] vram_data;
    logic [1:0] px;
    logic       px_valid;

    logic [7:0] cfg_lcdc;
    logic [7:0] cfg_scx;
    logic [7:0] cfg_scy;
    logic [7:0] cfg_lyc;
    logic [7:0] exp_ly;
    logic [7:0] rd_val;
    logic [3:0] seen;       // modes visited in the current line
    logic       line_known;
    int         line_cyc;
    int         px_x;
    int         lines_drawn;
    int         vblank_pulses;
    int         lcdc_pulses;
    int         cycles;
    int         errors;

    ppu_top u_ppu_top (
        .clk(clk), .rst(rst), .mmio(mmio), .rdata(rdata), .irq_vblank(irq_vblank),
        .irq_lcdc(irq_lcdc), .ppu_mode(ppu_mode), .vram(vram), .vram_data(vram_data),
        .px(px), .px_valid(px_valid)
    );

    bind ppu_top ppu_asserts u_asserts (
        .clk(clk), .rst(rst), .lcdc(lcdc), .ppu_mode(ppu_mode), .vram(vram),
        .px_valid(px_valid), .irq_lcdc(irq_lcdc), .irq_vblank(irq_vblank)
    );

    always #2 clk = ~clk;

    task automatic stop_run();
        errors++;
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("FAIL %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
            stop_run();
        end
    endtask

    function automatic logic [7:0] vram_byte(input logic [15:0] addr);
        return addr[7:0] ^ addr[15:8];
    endfunction

    // expected colour index of visible pixel x on a line, from the map and tile rules
    function automatic logic [1:0] ref_px(input logic [7:0] line, input int x);
        logic [7:0]  y;
        logic [7:0]  tnum;
        logic [7:0]  lo;
        logic [7:0]  hi;
        logic [15:0] map_addr;
        logic [15:0] data_addr;
        int          i;
        int          tn;
        int          base;
        y        = line + cfg_scy;
        i        = int'(cfg_scx[2:0]) + x; // index into the fetched pixel stream
        map_addr = (cfg_lcdc[3] ? 16'h9C00 : 16'h9800) + 16'(32 * int'(y[7:3]))
                 + 16'((int'(cfg_scx[7:3]) + i / 8) % 32);
        tnum     = vram_byte(map_addr);
        tn       = cfg_lcdc[4] ? int'(tnum) : int'($signed(tnum));
        base     = cfg_lcdc[4] ? 32'h8000 : 32'h9000;
        data_addr = 16'(base + 16 * tn + 2 * int'(y[2:0]));
        lo       = vram_byte(data_addr);
        hi       = vram_byte(data_addr + 16'd1);
        if (!cfg_lcdc[0]) begin
            return 2'b00;
        end
        return {hi[7 - i % 8], lo[7 - i % 8]};
    endfunction

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge clk);
        #1;
        mmio.addr  = addr;
        mmio.wdata = data;
        mmio.wr    = 1'b1;
        mmio.rd    = 1'b0;
        @(posedge clk);
        #1;
        mmio.wr = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        @(posedge clk);
        #1;
        mmio.addr = addr;
        mmio.rd   = 1'b1;
        #2;
        data = rdata;   // combinational read, sampled mid cycle
    endtask

    task automatic check_read(input logic [15:0] addr, input logic [7:0] expected,
                              input string name);
        logic [7:0] v;
        bus_read(addr, v);
        check_val(name, int'(expected), int'(v));
    endtask

    task automatic set_lcdc(input logic [7:0] v);
        bus_write(16'hFF40, v);
        cfg_lcdc = v;
    endtask

    task automatic set_scroll(input logic [7:0] x, input logic [7:0] y);
        bus_write(16'hFF43, x);
        bus_write(16'hFF42, y);
        cfg_scx = x;
        cfg_scy = y;
    endtask

    task automatic wait_ly(input logic [7:0] target);
        logic [7:0] v;
        v = ~target;
        while (v != target) begin
            bus_read(16'hFF44, v);
        end
    endtask

    // VRAM with one cycle of read latency
    always begin
        @(negedge clk);
        vram_req_q = vram;
        @(posedge clk);
        #1;
        if (vram_req_q.rd) begin
            vram_data = vram_byte(vram_req_q.addr);
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            check_val("bound assertions", 0, int'(u_ppu_top.u_asserts.failed));
            if (!cfg_lcdc[7]) begin
                line_known = 1'b0;
                exp_ly     = 8'd0;
                seen       = 4'b0000;
            end else if (u_ppu_top.line_ctrl.ly != exp_ly) begin
                check_val("ly", (exp_ly == 8'd153) ? 0 : int'(exp_ly) + 1,
                          int'(u_ppu_top.line_ctrl.ly));
                if (line_known) begin
                    check_val("line length", line_cycles, line_cyc);
                    check_val("line modes", (exp_ly < 8'd144) ? 13 : 2, int'(seen));
                end
                exp_ly = u_ppu_top.line_ctrl.ly;
                check_val("ppu_mode", (exp_ly < 8'd144) ? 2 : 1, int'(ppu_mode));
                line_known = 1'b1;
                line_cyc   = 1;
                seen       = 4'b0001 << ppu_mode;
            end else begin
                line_cyc++;
                seen = seen | (4'b0001 << ppu_mode);
            end
            if (px_valid) begin
                check_val("px", int'(ref_px(exp_ly, px_x)), int'(px));
                px_x++;
            end else if (ppu_mode != mode_draw && px_x != 0) begin
                check_val("px_valid count", 160, px_x);
                px_x = 0;
                lines_drawn++;
            end
            if (irq_vblank) begin
                check_val("ly at irq_vblank", 144, int'(exp_ly));
                vblank_pulses++;
            end
            if (irq_lcdc) begin
                check_val("ly at irq_lcdc", int'(cfg_lyc), int'(exp_ly));
                lcdc_pulses++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
            stop_run();
        end
    end

    initial begin
        void'($urandom(6497));
        rst  = 1'b1;
        mmio = '0;
        vram_data = 8'h00;
        {cfg_lcdc, cfg_scx, cfg_scy, exp_ly} = '0;
        {px_x, lines_drawn, vblank_pulses, lcdc_pulses, cycles, errors, line_cyc} = '0;
        line_known = 1'b0;
        seen       = 4'b0000;
        cfg_lyc    = 8'(1 + $urandom % 143);
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        bus_write(16'hFF40, 8'h5A);    // LCD stays off
        check_read(16'hFF40, 8'h5A, "lcdc");
        cfg_lcdc = 8'h5A;
        set_scroll(8'($urandom), 8'($urandom));
        check_read(16'hFF43, cfg_scx, "scx");
        check_read(16'hFF42, cfg_scy, "scy");
        bus_write(16'hFF45, cfg_lyc);
        check_read(16'hFF45, cfg_lyc, "lyc");
        bus_write(16'hFF41, 8'hFF);
        check_read(16'hFF41, {1'b1, 4'hF, 1'b0, 2'd2}, "stat");
        check_read(16'hFF44, 8'h00, "ly");
        bus_write(16'hFF46, 8'h12);
        check_read(16'hFF46, 8'hFF, "unmapped ff46");
        check_val("irq_lcdc pulses with lcd off", 0, lcdc_pulses);

        // full frame, unsigned tiles from map 9800
        bus_write(16'hFF41, 8'h40);
        set_lcdc(8'h91);
        wait_ly(cfg_lyc);
        bus_read(16'hFF41, rd_val);
        check_val("stat coincidence", 1, int'(rd_val[2]));
        check_val("irq_lcdc pulses", 1, lcdc_pulses);
        wait_ly(8'd0);
        check_val("irq_vblank pulses", 1, vblank_pulses);
        check_val("lines drawn", 144, lines_drawn);

        // signed tile numbers from map 9C00
        bus_write(16'hFF41, 8'h00);
        set_lcdc(8'h00);
        set_scroll(8'($urandom), 8'($urandom));
        set_lcdc(8'h89);
        wait_ly(8'd16);
        check_val("lines drawn", 160, lines_drawn);

        // background disabled
        set_lcdc(8'h00);
        set_lcdc(8'h90);
        wait_ly(8'd8);
        check_val("lines drawn", 168, lines_drawn);
        check_val("irq_lcdc pulses", 1, lcdc_pulses);

        if (errors == 0) begin
            $display("No errors");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

/* files.f */
rtl/ppu_pkg.sv
rtl/ppu_regs.sv
rtl/lcd_timing.sv
rtl/bg_fetcher.sv
rtl/pixel_fifo.sv
rtl/pixel_output.sv
rtl/ppu_top.sv
dv/ppu_asserts.sv
dv/ppu_tb.sv

/* rtl/bg_fetcher.sv */
// background tile fetcher; needs VRAM data exactly one cycle after rd, delivers a row 4 cycles after a trigger
`timescale 1ns/1ps

module bg_fetcher import ppu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  line_ctrl_t line_ctrl,
    input  lcdc_u      lcdc,
    input  logic [7:0] scx,
    input  logic [7:0] scy,
    input  logic       fetch_req,
    output vram_req_t  vram,
    input  logic [7:0] vram_data,
    output tile_row_t  row,
    output logic       row_valid
);

    localparam int max_fetch = screen_width / tile_px + 1; // one extra tile for fine scroll

    typedef enum logic [2:0] {st_idle, st_map, st_lo, st_hi, st_done} fetch_st_e;

    fetch_st_e   st;
    logic [4:0]  fetch_cnt;
    logic        in_draw;
    logic        trigger;
    logic [7:0]  bg_y;
    logic [4:0]  map_x;
    logic [15:0] map_addr;
    logic [15:0] tile_addr;
    logic [15:0] tile_addr_q;
    logic [7:0]  lo_q;

    assign in_draw = (line_ctrl.mode == mode_draw);
    assign trigger = line_ctrl.draw_start || (fetch_req && fetch_cnt < 5'(max_fetch));
    assign bg_y    = line_ctrl.ly + scy;           // wraps at 256
    assign map_x   = scx[7:3] + fetch_cnt;         // wraps at 32 tiles

    assign map_addr = (lcdc.flags.bg_map ? map_base_1 : map_base_0)
                    + 16'(bg_y[7:3]) * 16'(map_tiles) + 16'(map_x);

    // vram_data holds the tile number while in st_lo
    assign tile_addr = (lcdc.flags.tile_sel
                        ? tile_base_unsigned + {8'h00, vram_data} * 16'(tile_bytes)
                        : tile_base_signed + {{8{vram_data[7]}}, vram_data} * 16'(tile_bytes))
                     + {12'h000, bg_y[2:0], 1'b0};

    always_comb begin
        vram.rd   = in_draw && (st == st_map || st == st_lo || st == st_hi);
        vram.addr = map_addr;
        case (st)
            st_lo:   vram.addr = tile_addr;
            st_hi:   vram.addr = tile_addr_q + 16'd1;
            default: vram.addr = map_addr;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || !in_draw) begin
            st        <= st_idle;
            fetch_cnt <= 5'd0;
        end else begin
            if (trigger) begin
                st <= st_map;
            end else begin
                case (st)
                    st_map:  st <= st_lo;
                    st_lo:   st <= st_hi;
                    st_hi:   st <= st_done;
                    default: st <= st_idle;
                endcase
            end
            if (st == st_done) begin
                fetch_cnt <= fetch_cnt + 5'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (st == st_lo) begin
            tile_addr_q <= tile_addr;
        end
        if (st == st_hi) begin
            lo_q <= vram_data;     // low plane returns here
        end
    end

    assign row_valid    = (st == st_done);
    assign row.plane_hi = lcdc.flags.bg_en ? vram_data : 8'h00;
    assign row.plane_lo = lcdc.flags.bg_en ? lo_q : 8'h00;

endmodule

/* rtl/lcd_timing.sv */
// dot and line sequencer; draw length is set by line_done, which must arrive before the line ends
`timescale 1ns/1ps

module lcd_timing import ppu_pkg::*; #(
    parameter int dots_per_line = 456,
    parameter int scan_dots     = 80,
    parameter int visible_lines = 144,
    parameter int total_lines   = 154
) (
    input  logic       clk,
    input  logic       rst,
    input  lcdc_u      lcdc,
    input  logic       line_done,
    output line_ctrl_t line_ctrl,
    output logic       irq_vblank
);

    logic [8:0] dot;
    logic [7:0] ly_next;

    assign ly_next = (line_ctrl.ly == 8'(total_lines - 1)) ? 8'd0 : line_ctrl.ly + 8'd1;

    always_ff @(posedge clk) begin
        if (rst || !lcdc.flags.lcd_en) begin
            dot                  <= 9'd0;
            line_ctrl.ly         <= 8'd0;
            line_ctrl.mode       <= mode_oam_scan;
            line_ctrl.draw_start <= 1'b0;
            irq_vblank           <= 1'b0;
        end else begin
            line_ctrl.draw_start <= 1'b0;
            irq_vblank           <= 1'b0;
            if (dot == 9'(dots_per_line - 1)) begin
                dot          <= 9'd0;
                line_ctrl.ly <= ly_next;
                if (ly_next >= 8'(visible_lines)) begin
                    line_ctrl.mode <= mode_vblank;
                end else begin
                    line_ctrl.mode <= mode_oam_scan;
                end
                irq_vblank <= (ly_next == 8'(visible_lines)); // first vblank line only
            end else begin
                dot <= dot + 9'd1;
                if (line_ctrl.mode == mode_oam_scan && dot == 9'(scan_dots - 1)) begin
                    line_ctrl.mode       <= mode_draw;
                    line_ctrl.draw_start <= 1'b1;
                end else if (line_ctrl.mode == mode_draw && line_done) begin
                    line_ctrl.mode <= mode_hblank;
                end
            end
        end
    end

endmodule

/* rtl/pixel_fifo.sv */
// one pending tile row plus an 8-pixel shifter; an incoming row must find the pending slot empty
`timescale 1ns/1ps

module pixel_fifo import ppu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  line_ctrl_t line_ctrl,
    input  tile_row_t  row,
    input  logic       row_valid,
    output logic       fetch_req,
    output logic [1:0] px,
    output logic       px_strobe
);

    tile_row_t  pend;
    logic       pend_valid;
    logic [7:0] sh_hi;
    logic [7:0] sh_lo;
    logic [3:0] sh_cnt;
    logic       active;
    logic       load;

    assign active    = (line_ctrl.mode == mode_draw) && !line_ctrl.draw_start;
    assign load      = active && pend_valid && (sh_cnt == 4'd0);
    assign fetch_req = load;                      // ask for the next tile as the slot frees
    assign px_strobe = active && (sh_cnt != 4'd0);
    assign px        = {sh_hi[7], sh_lo[7]};

    always_ff @(posedge clk) begin
        if (rst || line_ctrl.draw_start) begin
            pend_valid <= 1'b0;
            sh_cnt     <= 4'd0;
        end else begin
            if (load) begin
                pend_valid <= 1'b0;
                sh_cnt     <= 4'd8;
            end else if (px_strobe) begin
                sh_cnt <= sh_cnt - 4'd1;
            end
            if (row_valid) begin
                pend_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (row_valid) begin
            pend <= row;
        end
        if (load) begin
            sh_hi <= pend.plane_hi;
            sh_lo <= pend.plane_lo;
        end else if (px_strobe) begin
            sh_hi <= {sh_hi[6:0], 1'b0};
            sh_lo <= {sh_lo[6:0], 1'b0};
        end
    end

endmodule

/* rtl/pixel_output.sv */
// drops SCX mod 8 leading pixels and forwards exactly 160 per line, registered
`timescale 1ns/1ps

module pixel_output import ppu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  line_ctrl_t line_ctrl,
    input  logic [7:0] scx,
    input  logic [1:0] px,
    input  logic       px_strobe,
    output logic [1:0] px_out,
    output logic       px_valid,
    output logic       line_done
);

    logic [7:0] in_cnt;   // pixels seen since draw_start
    logic [7:0] out_cnt;  // visible pixels forwarded
    logic       keep;

    assign keep = px_strobe && (in_cnt >= {5'd0, scx[2:0]}) && (out_cnt < 8'(screen_width));

    always_ff @(posedge clk) begin
        if (rst || line_ctrl.draw_start) begin
            in_cnt    <= 8'd0;
            out_cnt   <= 8'd0;
            px_valid  <= 1'b0;
            line_done <= 1'b0;
        end else begin
            if (px_strobe) begin
                in_cnt <= in_cnt + 8'd1;
            end
            if (keep) begin
                out_cnt <= out_cnt + 8'd1;
            end
            px_valid  <= keep;
            line_done <= px_valid && (out_cnt == 8'(screen_width)); // after the last pixel
        end
    end

    always_ff @(posedge clk) begin
        if (keep) begin
            px_out <= px;
        end
    end

endmodule

/* rtl/ppu_pkg.sv */
// shared PPU definitions; only the background path is modelled, no sprite or window fields are decoded
package ppu_pkg;

    localparam logic [15:0] addr_lcdc = 16'hFF40;
    localparam logic [15:0] addr_stat = 16'hFF41;
    localparam logic [15:0] addr_scy  = 16'hFF42;
    localparam logic [15:0] addr_scx  = 16'hFF43;
    localparam logic [15:0] addr_ly   = 16'hFF44;
    localparam logic [15:0] addr_lyc  = 16'hFF45;

    localparam logic [15:0] map_base_0         = 16'h9800;
    localparam logic [15:0] map_base_1         = 16'h9C00;
    localparam logic [15:0] tile_base_unsigned = 16'h8000;
    localparam logic [15:0] tile_base_signed   = 16'h9000; // 8800 mode, tile 0 sits in the middle

    localparam int screen_width = 160;
    localparam int tile_px      = 8;
    localparam int map_tiles    = 32;
    localparam int tile_bytes   = 16;

    typedef enum logic [1:0] {
        mode_hblank   = 2'd0,
        mode_vblank   = 2'd1,
        mode_oam_scan = 2'd2,
        mode_draw     = 2'd3
    } ppu_mode_e; // same encoding as STAT[1:0]

    typedef struct packed {
        logic lcd_en;
        logic win_map;  // stored only
        logic win_en;   // stored only
        logic tile_sel; // 1 = 8000 unsigned, 0 = 8800 signed
        logic bg_map;   // 1 = 9C00
        logic obj_size; // stored only
        logic obj_en;   // stored only
        logic bg_en;
    } lcdc_flags_t;

    typedef union packed {
        logic [7:0]  raw;
        lcdc_flags_t flags;
    } lcdc_u;

    typedef struct packed {
        logic [15:0] addr;
        logic        wr;
        logic        rd;
        logic [7:0]  wdata;
    } mmio_bus_t;

    typedef struct packed {
        logic        rd;
        logic [15:0] addr;
    } vram_req_t;

    typedef struct packed {
        logic [7:0] plane_hi;
        logic [7:0] plane_lo;
    } tile_row_t;

    typedef struct packed {
        ppu_mode_e  mode;
        logic [7:0] ly;
        logic       draw_start; // high for the first draw cycle of a line
    } line_ctrl_t;

endpackage

/* rtl/ppu_regs.sv */
// PPU register file at FF40-FF45; reads are combinational and any other address returns FF
`timescale 1ns/1ps

module ppu_regs import ppu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  mmio_bus_t  mmio,
    output logic [7:0] rdata,
    input  line_ctrl_t line_ctrl,
    output lcdc_u      lcdc,
    output logic [7:0] scx,
    output logic [7:0] scy,
    output logic       irq_lcdc
);

    logic [7:0] lyc;
    logic [3:0] stat_en;  // STAT bits 6:3
    logic       coinc;
    logic       stat_cond;
    logic       stat_prev;
    logic [7:0] stat_rd;

    assign coinc   = (line_ctrl.ly == lyc);
    assign stat_rd = {1'b1, stat_en, coinc, line_ctrl.mode};

    always_ff @(posedge clk) begin
        if (rst) begin
            lcdc.raw <= 8'h00;
            scy      <= 8'h00;
            scx      <= 8'h00;
            lyc      <= 8'h00;
            stat_en  <= 4'h0;
        end else if (mmio.wr) begin
            case (mmio.addr)
                addr_lcdc: lcdc.raw <= mmio.wdata;
                addr_stat: stat_en  <= mmio.wdata[6:3]; // low bits are status only
                addr_scy:  scy      <= mmio.wdata;
                addr_scx:  scx      <= mmio.wdata;
                addr_lyc:  lyc      <= mmio.wdata;
                default:   ;                            // LY and unmapped ignore writes
            endcase
        end
    end

    always_comb begin
        rdata = 8'hFF;
        if (mmio.rd) begin
            case (mmio.addr)
                addr_lcdc: rdata = lcdc.raw;
                addr_stat: rdata = stat_rd;
                addr_scy:  rdata = scy;
                addr_scx:  rdata = scx;
                addr_ly:   rdata = line_ctrl.ly;
                addr_lyc:  rdata = lyc;
                default:   rdata = 8'hFF;
            endcase
        end
    end

    // combined STAT line, bit 6 lyc, bit 5 oam, bit 4 vblank, bit 3 hblank
    assign stat_cond = lcdc.flags.lcd_en &&
                       ((stat_en[3] && coinc) ||
                        (stat_en[0] && line_ctrl.mode == mode_hblank) ||
                        (stat_en[2] && line_ctrl.mode == mode_oam_scan) ||
                        (stat_en[1] && line_ctrl.mode == mode_vblank));

    always_ff @(posedge clk) begin
        if (rst) begin
            stat_prev <= 1'b0;
        end else begin
            stat_prev <= stat_cond;
        end
    end

    assign irq_lcdc = stat_cond && !stat_prev; // rising edge only

endmodule

/* rtl/ppu_top.sv */
// background-only PPU top; VRAM must answer one cycle after rd, timing parameters go to lcd_timing
`timescale 1ns/1ps

module ppu_top import ppu_pkg::*; #(
    parameter int dots_per_line = 456,
    parameter int scan_dots     = 80,
    parameter int visible_lines = 144,
    parameter int total_lines   = 154
) (
    input  logic       clk,
    input  logic       rst,
    input  mmio_bus_t  mmio,
    output logic [7:0] rdata,
    output logic       irq_vblank,
    output logic       irq_lcdc,
    output ppu_mode_e  ppu_mode,
    output vram_req_t  vram,
    input  logic [7:0] vram_data,
    output logic [1:0] px,
    output logic       px_valid
);

    line_ctrl_t line_ctrl;
    lcdc_u      lcdc;
    logic [7:0] scx;
    logic [7:0] scy;
    tile_row_t  row;
    logic       row_valid;
    logic       fetch_req;
    logic [1:0] fifo_px;
    logic       px_strobe;
    logic       line_done;

    assign ppu_mode = line_ctrl.mode;

    ppu_regs u_regs (
        .clk(clk), .rst(rst), .mmio(mmio), .rdata(rdata), .line_ctrl(line_ctrl),
        .lcdc(lcdc), .scx(scx), .scy(scy), .irq_lcdc(irq_lcdc)
    );

    lcd_timing #(
        .dots_per_line(dots_per_line), .scan_dots(scan_dots),
        .visible_lines(visible_lines), .total_lines(total_lines)
    ) u_timing (
        .clk(clk), .rst(rst), .lcdc(lcdc), .line_done(line_done),
        .line_ctrl(line_ctrl), .irq_vblank(irq_vblank)
    );

    bg_fetcher u_fetcher (
        .clk(clk), .rst(rst), .line_ctrl(line_ctrl), .lcdc(lcdc), .scx(scx), .scy(scy),
        .fetch_req(fetch_req), .vram(vram), .vram_data(vram_data),
        .row(row), .row_valid(row_valid)
    );

    pixel_fifo u_fifo (
        .clk(clk), .rst(rst), .line_ctrl(line_ctrl), .row(row), .row_valid(row_valid),
        .fetch_req(fetch_req), .px(fifo_px), .px_strobe(px_strobe)
    );

    pixel_output u_output (
        .clk(clk), .rst(rst), .line_ctrl(line_ctrl), .scx(scx), .px(fifo_px),
        .px_strobe(px_strobe), .px_out(px), .px_valid(px_valid), .line_done(line_done)
    );

endmodule

/* run.sh */
#!/bin/sh
# builds the PPU testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module ppu_tb -o ppu_sim
./obj_dir/ppu_sim +verilator+error+limit+100 | tee sim.log
grep -qx "No errors" sim.log
